//--- tb.f
+incdir+hdl
+incdir+test
hdl/conv_pkg.sv
hdl/axis_reg_slice.sv
hdl/pixel_unpacker.sv
hdl/weight_gatherer.sv
hdl/stream_joiner.sv
hdl/conv_input_pipe.sv
test/tb_conv_input_pipe.sv

//--- test/conv_input_table.svh
`ifndef CONV_INPUT_TABLE_SVH
`define CONV_INPUT_TABLE_SVH

// one row per layer, pixel and weight packet sent together.
// columns: pixel header flags, weight header flags, data beats N, seed byte.
// data byte = seed + index, mod 256. pixel index is beat * 8 + word,
// weight index is WEIGHT_INDEX_BASE + dma beat * 4 + byte.

localparam int NUM_PACKETS       = 8;
localparam int WEIGHT_INDEX_BASE = 64;

typedef struct packed {
  logic [3:0] pix_hdr; // kernel_h_1, is_lrelu, is_max from the msb.
  logic [4:0] wgt_hdr; // kernel_w_1, is_1x1, is_bottom_block, is_top_block.
  logic [2:0] n;
  logic [7:0] seed;
} packet_t;

function automatic packet_t packet_entry(input int idx);
  packet_t row;
  case (idx)
    0:       row = {4'h1, 5'h01, 3'd1, 8'h00};
    1:       row = {4'ha, 5'h16, 3'd4, 8'h3c};
    2:       row = {4'h5, 5'h0b, 3'd1, 8'he0}; // bytes wrap past 255.
    3:       row = {4'hf, 5'h1f, 3'd4, 8'hc8};
    4:       row = {4'h0, 5'h00, 3'd2, 8'h7f};
    5:       row = {4'h6, 5'h12, 3'd3, 8'hf5};
    6:       row = {4'h9, 5'h0c, 3'd1, 8'h21};
    7:       row = {4'h3, 5'h05, 3'd4, 8'h99};
    default: row = '0;
  endcase
  return row;
endfunction

`endif

//--- test/tb_conv_input_pipe.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module tb_conv_input_pipe;

  import conv_pkg::*;

  localparam int W              = `CONV_WORD_WIDTH;
  localparam int PIX_BITS       = `CONV_PIXEL_WORDS * W;
  localparam int DMA_BYTES      = `CONV_DMA_BITS / W;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] SEED  = 32'd97;

  `include "conv_input_table.svh"

  logic                                 aclk;
  logic                                 reset;
  logic                                 pixel_tvalid;
  logic                                 pixel_tready;
  logic [PIX_BITS-1:0]                  pixel_tdata;
  logic                                 pixel_tlast;
  logic                                 weight_tvalid;
  logic                                 weight_tready;
  logic [`CONV_DMA_BITS-1:0]            weight_tdata;
  logic                                 weight_tlast;
  logic                                 conv_tvalid;
  logic                                 conv_tready;
  logic [`CONV_UNITS_EDGES*W-1:0]       conv_tdata_pixels;
  logic [`CONV_WEIGHT_WORDS*W-1:0]      conv_tdata_weights;
  conv_tuser_t                          conv_tuser;
  logic                                 conv_tlast;

  // separate states keep the three random streams independent.
  logic [31:0] pix_rng = SEED;
  logic [31:0] wgt_rng = SEED + 1;
  logic [31:0] rdy_rng = SEED + 2;

  int pix_beats_sent  = 0;
  int wgt_groups_sent = 0;
  int conv_seen       = 0;

  conv_input_pipe UUT (
    .aclk               (aclk),
    .reset              (reset),
    .pixel_tvalid       (pixel_tvalid),
    .pixel_tready       (pixel_tready),
    .pixel_tdata        (pixel_tdata),
    .pixel_tlast        (pixel_tlast),
    .weight_tvalid      (weight_tvalid),
    .weight_tready      (weight_tready),
    .weight_tdata       (weight_tdata),
    .weight_tlast       (weight_tlast),
    .conv_tvalid        (conv_tvalid),
    .conv_tready        (conv_tready),
    .conv_tdata_pixels  (conv_tdata_pixels),
    .conv_tdata_weights (conv_tdata_weights),
    .conv_tuser         (conv_tuser),
    .conv_tlast         (conv_tlast)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string msg);
    $display("Fail at %t: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic wait_timeout(input string what);
    $display("Timed out while waiting: %s", what);
    stop_with_failure();
  endtask

  // random back-pressure, about one cycle in four.
  initial begin
    conv_tready = 1'b0;
    forever begin
      @(negedge aclk);
      rdy_rng     = xorshift32(rdy_rng);
      conv_tready = !reset && (rdy_rng[1:0] != 2'b00);
    end
  end

  // called on a falling edge, returns on the falling edge after the transfer.
  task automatic send_pixel_beat(input logic [PIX_BITS-1:0] data, input logic last);
    int gap;
    int waited;
    pix_rng = xorshift32(pix_rng);
    gap     = (pix_rng[1:0] == 2'b00) ? int'(pix_rng[3:2]) + 1 : 0;
    if (gap > 0) begin
      pixel_tvalid = 1'b0;
      repeat (gap) @(negedge aclk);
    end
    pixel_tvalid = 1'b1;
    pixel_tdata  = data;
    pixel_tlast  = last;
    waited       = 0;
    #1;
    while (pixel_tready !== 1'b1) begin
      if (waited == TIMEOUT_CYCLES) wait_timeout("pixel_tready never went high");
      waited++;
      @(negedge aclk);
      #1;
    end
    @(negedge aclk);
  endtask

  task automatic send_weight_beat(input logic [`CONV_DMA_BITS-1:0] data, input logic last);
    int gap;
    int waited;
    wgt_rng = xorshift32(wgt_rng);
    gap     = (wgt_rng[1:0] == 2'b00) ? int'(wgt_rng[3:2]) + 1 : 0;
    if (gap > 0) begin
      weight_tvalid = 1'b0;
      repeat (gap) @(negedge aclk);
    end
    weight_tvalid = 1'b1;
    weight_tdata  = data;
    weight_tlast  = last;
    waited        = 0;
    #1;
    while (weight_tready !== 1'b1) begin
      if (waited == TIMEOUT_CYCLES) wait_timeout("weight_tready never went high");
      waited++;
      @(negedge aclk);
      #1;
    end
    @(negedge aclk);
  endtask

  task automatic drive_pixels();
    packet_t             pk;
    logic [PIX_BITS-1:0] data;
    int                  p;
    int                  b;
    int                  w;
    for (p = 0; p < NUM_PACKETS; p++) begin
      pk      = packet_entry(p);
      pix_rng = xorshift32(pix_rng);
      data    = PIX_BITS'({2{pix_rng}}); // junk above the flags.
      data[3:0] = pk.pix_hdr;
      send_pixel_beat(data, 1'b0);
      for (b = 0; b < pk.n; b++) begin
        for (w = 0; w < `CONV_PIXEL_WORDS; w++) begin
          data[w*W +: W] = pk.seed + b * `CONV_PIXEL_WORDS + w;
        end
        send_pixel_beat(data, b == pk.n - 1);
        pix_beats_sent++;
      end
    end
    pixel_tvalid = 1'b0;
  endtask

  task automatic drive_weights();
    packet_t                   pk;
    logic [`CONV_DMA_BITS-1:0] data;
    int                        p;
    int                        d;
    int                        k;
    repeat (20) @(negedge aclk); // pixels run ahead, joiner must wait.
    for (p = 0; p < NUM_PACKETS; p++) begin
      pk        = packet_entry(p);
      wgt_rng   = xorshift32(wgt_rng);
      data      = wgt_rng;
      data[4:0] = pk.wgt_hdr;
      send_weight_beat(data, 1'b0);
      for (d = 0; d < pk.n * `CONV_DMA_PER_WEIGHT; d++) begin
        for (k = 0; k < DMA_BYTES; k++) begin
          data[k*W +: W] = pk.seed + WEIGHT_INDEX_BASE + d * DMA_BYTES + k;
        end
        send_weight_beat(data, d == pk.n * `CONV_DMA_PER_WEIGHT - 1);
        if (d % `CONV_DMA_PER_WEIGHT == `CONV_DMA_PER_WEIGHT - 1) wgt_groups_sent++;
      end
    end
    weight_tvalid = 1'b0;
  endtask

  // every valid cycle is compared, so a stalled beat must hold its payload.
  task automatic check_conv_beats();
    packet_t                         pk;
    logic [`CONV_UNITS_EDGES*W-1:0]  exp_pix;
    logic [`CONV_WEIGHT_WORDS*W-1:0] exp_wgt;
    logic [8:0]                      exp_user;
    logic                            exp_last;
    logic                            accepted;
    int                              p;
    int                              j;
    int                              i;
    int                              idx;
    int                              waited;
    for (p = 0; p < NUM_PACKETS; p++) begin
      pk = packet_entry(p);
      for (j = 0; j < pk.n; j++) begin
        for (i = 0; i < `CONV_UNITS_EDGES; i++) begin
          exp_pix[i*W +: W] = pk.seed + j * `CONV_PIXEL_WORDS + i;
        end
        for (i = 0; i < `CONV_WEIGHT_WORDS; i++) begin
          idx = (j * `CONV_DMA_PER_WEIGHT + i / DMA_BYTES) * DMA_BYTES + i % DMA_BYTES;
          exp_wgt[i*W +: W] = pk.seed + WEIGHT_INDEX_BASE + idx;
        end
        exp_user = {pk.wgt_hdr, pk.pix_hdr}; // pixel flags in the low bits.
        exp_last = (j == pk.n - 1);
        accepted = 1'b0;
        waited   = 0;
        while (!accepted) begin
          if (waited == TIMEOUT_CYCLES) begin
            wait_timeout($sformatf("conv beat %0d of packet %0d never arrived", j, p));
          end
          waited++;
          @(negedge aclk);
          #1;
          if (conv_tvalid === 1'b1) begin
            assert (conv_seen < pix_beats_sent && conv_seen < wgt_groups_sent)
              else value_mismatch("conv_tvalid high before both inputs delivered data");
            assert (conv_tdata_pixels === exp_pix)
              else value_mismatch($sformatf("packet %0d beat %0d pixels %h, expected %h",
                                            p, j, conv_tdata_pixels, exp_pix));
            assert (conv_tdata_weights === exp_wgt)
              else value_mismatch($sformatf("packet %0d beat %0d weights %h, expected %h",
                                            p, j, conv_tdata_weights, exp_wgt));
            assert (conv_tuser === exp_user)
              else value_mismatch($sformatf("packet %0d beat %0d tuser %h, expected %h",
                                            p, j, conv_tuser, exp_user));
            assert (conv_tlast === exp_last)
              else value_mismatch($sformatf("packet %0d beat %0d tlast %b, expected %b",
                                            p, j, conv_tlast, exp_last));
            accepted = (conv_tready === 1'b1);
          end
        end
        conv_seen++;
      end
    end
  endtask

  initial begin
    int cyc;
    $timeformat(-9, 1, " ns", 0);
    reset         = 1'b1;
    pixel_tvalid  = 1'b0;
    pixel_tdata   = '0;
    pixel_tlast   = 1'b0;
    weight_tvalid = 1'b0;
    weight_tdata  = '0;
    weight_tlast  = 1'b0;
    @(posedge aclk); // first reset edge.
    for (cyc = 0; cyc < 10; cyc++) begin
      @(negedge aclk);
      assert (conv_tvalid === 1'b0) else value_mismatch("conv_tvalid high during reset");
      assert (pixel_tready === 1'b0) else value_mismatch("pixel_tready high during reset");
      assert (weight_tready === 1'b0) else value_mismatch("weight_tready high during reset");
    end
    reset = 1'b0;

    fork
      drive_pixels();
      drive_weights();
      check_conv_beats();
    join

    // nothing may follow the last packet.
    for (cyc = 0; cyc < 10; cyc++) begin
      @(negedge aclk);
      assert (conv_tvalid === 1'b0) else value_mismatch("extra conv beat after last packet");
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- hdl/conv_input_pipe.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module conv_input_pipe (
  input  logic                                           aclk,
  input  logic                                           reset,

  input  logic                                           pixel_tvalid,
  output logic                                           pixel_tready,
  input  logic [`CONV_PIXEL_WORDS*`CONV_WORD_WIDTH-1:0]  pixel_tdata,
  input  logic                                           pixel_tlast,

  input  logic                                           weight_tvalid,
  output logic                                           weight_tready,
  input  logic [`CONV_DMA_BITS-1:0]                      weight_tdata,
  input  logic                                           weight_tlast,

  output logic                                           conv_tvalid,
  input  logic                                           conv_tready,
  output logic [`CONV_UNITS_EDGES*`CONV_WORD_WIDTH-1:0]  conv_tdata_pixels,
  output logic [`CONV_WEIGHT_WORDS*`CONV_WORD_WIDTH-1:0] conv_tdata_weights,
  output conv_pkg::conv_tuser_t                          conv_tuser,
  output logic                                           conv_tlast
);

  import conv_pkg::*;

  // unpacker/gatherer to slice.
  logic         pix_up_valid;
  logic         pix_up_ready;
  pixel_beat_t  pix_up_beat;
  logic         wgt_up_valid;
  logic         wgt_up_ready;
  weight_beat_t wgt_up_beat;

  // slice to joiner.
  logic         pix_valid;
  logic         pix_ready;
  pixel_beat_t  pix_beat;
  logic         wgt_valid;
  logic         wgt_ready;
  weight_beat_t wgt_beat;

  pixel_unpacker u_pixel_unpacker (
    .aclk         (aclk),
    .reset        (reset),
    .pixel_tvalid (pixel_tvalid),
    .pixel_tready (pixel_tready),
    .pixel_tdata  (pixel_tdata),
    .pixel_tlast  (pixel_tlast),
    .out_valid    (pix_up_valid),
    .out_ready    (pix_up_ready),
    .out_beat     (pix_up_beat)
  );

  weight_gatherer u_weight_gatherer (
    .aclk          (aclk),
    .reset         (reset),
    .weight_tvalid (weight_tvalid),
    .weight_tready (weight_tready),
    .weight_tdata  (weight_tdata),
    .weight_tlast  (weight_tlast),
    .out_valid     (wgt_up_valid),
    .out_ready     (wgt_up_ready),
    .out_beat      (wgt_up_beat)
  );

  axis_reg_slice #(.payload_t(pixel_beat_t)) u_pixel_slice (
    .aclk      (aclk),
    .reset     (reset),
    .in_valid  (pix_up_valid),
    .in_ready  (pix_up_ready),
    .in_data   (pix_up_beat),
    .out_valid (pix_valid),
    .out_ready (pix_ready),
    .out_data  (pix_beat)
  );

  axis_reg_slice #(.payload_t(weight_beat_t)) u_weight_slice (
    .aclk      (aclk),
    .reset     (reset),
    .in_valid  (wgt_up_valid),
    .in_ready  (wgt_up_ready),
    .in_data   (wgt_up_beat),
    .out_valid (wgt_valid),
    .out_ready (wgt_ready),
    .out_data  (wgt_beat)
  );

  stream_joiner u_stream_joiner (
    .aclk               (aclk),
    .pix_valid          (pix_valid),
    .pix_ready          (pix_ready),
    .pix_beat           (pix_beat),
    .wgt_valid          (wgt_valid),
    .wgt_ready          (wgt_ready),
    .wgt_beat           (wgt_beat),
    .conv_tvalid        (conv_tvalid),
    .conv_tready        (conv_tready),
    .conv_tdata_pixels  (conv_tdata_pixels),
    .conv_tdata_weights (conv_tdata_weights),
    .conv_tuser         (conv_tuser),
    .conv_tlast         (conv_tlast)
  );

endmodule

//--- hdl/stream_joiner.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module stream_joiner (
  input  logic                                            aclk,
  input  logic                                            pix_valid,
  output logic                                            pix_ready,
  input  conv_pkg::pixel_beat_t                           pix_beat,
  input  logic                                            wgt_valid,
  output logic                                            wgt_ready,
  input  conv_pkg::weight_beat_t                          wgt_beat,
  output logic                                            conv_tvalid,
  input  logic                                            conv_tready,
  output logic [`CONV_UNITS_EDGES*`CONV_WORD_WIDTH-1:0]   conv_tdata_pixels,
  output logic [`CONV_WEIGHT_WORDS*`CONV_WORD_WIDTH-1:0]  conv_tdata_weights,
  output conv_pkg::conv_tuser_t                           conv_tuser,
  output logic                                            conv_tlast
);

  // a side is popped only when the other side pops with it.
  assign conv_tvalid = pix_valid & wgt_valid;
  assign pix_ready   = conv_tready & wgt_valid;
  assign wgt_ready   = conv_tready & pix_valid;

  assign conv_tdata_pixels  = pix_beat.data;
  assign conv_tdata_weights = wgt_beat.data;

  assign conv_tuser.pix = pix_beat.tuser;
  assign conv_tuser.wgt = wgt_beat.tuser;

  assign conv_tlast = pix_beat.last; // weight last is the same when in step.

  // both packets of a layer must carry the same number of beats.
  a_last_aligned: assert property (
    @(posedge aclk)
    conv_tvalid && conv_tready |-> pix_beat.last == wgt_beat.last
  );

endmodule

//--- hdl/weight_gatherer.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module weight_gatherer (
  input  logic                      aclk,
  input  logic                      reset,
  input  logic                      weight_tvalid,
  output logic                      weight_tready,
  input  logic [`CONV_DMA_BITS-1:0] weight_tdata,
  input  logic                      weight_tlast,
  output logic                      out_valid,
  input  logic                      out_ready,
  output conv_pkg::weight_beat_t    out_beat
);

  import conv_pkg::*;

  localparam int DMA_WORDS  = `CONV_DMA_BITS / `CONV_WORD_WIDTH;
  localparam int PART_WORDS = (`CONV_DMA_PER_WEIGHT - 1) * DMA_WORDS;
  localparam int CNT_W      = $clog2(`CONV_DMA_PER_WEIGHT);

  logic [DMA_WORDS-1:0][`CONV_WORD_WIDTH-1:0]  dma_words;
  logic [PART_WORDS-1:0][`CONV_WORD_WIDTH-1:0] part_q;
  logic [CNT_W-1:0] count;
  logic             is_header;
  logic             last_dma;
  logic             take;
  weight_tuser_t    tuser_q;

  assign dma_words = weight_tdata; // byte 0 is word 0.
  assign last_dma  = (count == CNT_W'(`CONV_DMA_PER_WEIGHT - 1));

  // only the closing beat of a group needs a free output register.
  assign weight_tready = ~reset & (is_header | ~last_dma | ~out_valid | out_ready);
  assign take          = weight_tvalid & weight_tready;

  always_ff @(posedge aclk) begin
    if (reset) begin
      is_header <= 1'b1;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (take && !is_header && last_dma) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end

      if (take && !is_header) begin
        count <= last_dma ? '0 : count + 1'b1;
      end

      if (take) begin
        is_header <= is_header ? 1'b0 : weight_tlast;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take && is_header) begin
      tuser_q <= weight_tuser_t'(weight_tdata[$bits(weight_tuser_t)-1:0]);
    end
  end

  // older dma beats shift down toward word 0.
  always_ff @(posedge aclk) begin
    if (take && !is_header && !last_dma) begin
      part_q <= {dma_words, part_q[PART_WORDS-1:DMA_WORDS]};
    end
  end

  always_ff @(posedge aclk) begin
    if (take && !is_header && last_dma) begin
      out_beat.data  <= {dma_words, part_q};
      out_beat.tuser <= tuser_q;
      out_beat.last  <= weight_tlast;
    end
  end

  // a weight packet holds whole groups only.
  a_tlast_on_group_end: assert property (
    @(posedge aclk) disable iff (reset)
    weight_tvalid && !is_header && weight_tlast |-> last_dma
  );

endmodule

//--- hdl/pixel_unpacker.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module pixel_unpacker (
  input  logic                                          aclk,
  input  logic                                          reset,
  input  logic                                          pixel_tvalid,
  output logic                                          pixel_tready,
  input  logic [`CONV_PIXEL_WORDS*`CONV_WORD_WIDTH-1:0] pixel_tdata,
  input  logic                                          pixel_tlast,
  output logic                                          out_valid,
  input  logic                                          out_ready,
  output conv_pkg::pixel_beat_t                         out_beat
);

  import conv_pkg::*;

  logic [`CONV_PIXEL_WORDS-1:0][`CONV_WORD_WIDTH-1:0] in_words;
  logic         is_header;
  logic         take;
  pixel_tuser_t tuser_q;

  assign in_words = pixel_tdata;

  // headers are swallowed, so they never need room downstream.
  assign pixel_tready = ~reset & (is_header | ~out_valid | out_ready);
  assign take         = pixel_tvalid & pixel_tready;

  always_ff @(posedge aclk) begin
    if (reset) begin
      is_header <= 1'b1;
      out_valid <= 1'b0;
    end else begin
      if (take && !is_header) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end

      if (take) begin
        is_header <= is_header ? 1'b0 : pixel_tlast; // next packet after tlast.
      end
    end
  end

  // layer flags, held for the whole packet.
  always_ff @(posedge aclk) begin
    if (take && is_header) begin
      tuser_q <= pixel_tuser_t'(in_words[0][$bits(pixel_tuser_t)-1:0]);
    end
  end

  always_ff @(posedge aclk) begin
    if (take && !is_header) begin
      out_beat.data  <= in_words[`CONV_UNITS_EDGES-1:0]; // padding words dropped.
      out_beat.tuser <= tuser_q;
      out_beat.last  <= pixel_tlast;
    end
  end

  // a packet must have at least one data beat after its header.
  a_header_not_last: assert property (
    @(posedge aclk) disable iff (reset)
    pixel_tvalid && is_header |-> !pixel_tlast
  );

endmodule

//--- hdl/axis_reg_slice.sv
`timescale 1ns/1ps

module axis_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     main_valid;
  logic     skid_valid;
  payload_t main_data;
  payload_t skid_data;
  logic     main_load;
  logic     skid_load;

  // main register is free when empty or being drained this cycle.
  assign main_load = out_ready | ~main_valid;

  // stalled with a beat arriving, park it in the skid.
  assign skid_load = in_valid & in_ready & ~main_load;

  assign in_ready  = ~skid_valid; // straight from a flop.
  assign out_valid = main_valid;
  assign out_data  = main_data;

  always_ff @(posedge aclk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_load) begin
        main_valid <= skid_valid | in_valid;
        skid_valid <= 1'b0;
      end else if (skid_load) begin
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (main_load && (skid_valid || in_valid)) begin
      main_data <= skid_valid ? skid_data : in_data; // skid is older.
    end
    if (skid_load) begin
      skid_data <= in_data;
    end
  end

  a_hold_when_stalled: assert property (
    @(posedge aclk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

//--- hdl/conv_pkg.sv
`include "conv_defs.svh"

package conv_pkg;

  typedef logic [`CONV_UNITS_EDGES-1:0][`CONV_WORD_WIDTH-1:0]  pixel_words_t;
  typedef logic [`CONV_WEIGHT_WORDS-1:0][`CONV_WORD_WIDTH-1:0] weight_words_t;

  // first listed field sits in the msb, so is_max lands on bit 0.
  typedef struct packed {
    logic [1:0] kernel_h_1;
    logic       is_lrelu;
    logic       is_max;
  } pixel_tuser_t;

  // is_top_block on bit 0.
  typedef struct packed {
    logic [1:0] kernel_w_1;
    logic       is_1x1;
    logic       is_bottom_block;
    logic       is_top_block;
  } weight_tuser_t;

  // pixel flags in the low bits, weight flags above them.
  typedef struct packed {
    weight_tuser_t wgt;
    pixel_tuser_t  pix;
  } conv_tuser_t;

  typedef struct packed {
    pixel_words_t data;
    pixel_tuser_t tuser;
    logic         last;
  } pixel_beat_t;

  typedef struct packed {
    weight_words_t data;
    weight_tuser_t tuser;
    logic          last;
  } weight_beat_t;

endpackage

//--- hdl/conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// array geometry.
`define CONV_UNITS        3
`define CONV_WORD_WIDTH   8
`define CONV_KERNEL_H_MAX 3
`define CONV_KERNEL_W_MAX 3
`define CONV_CORES        4

// rows on a pixel beat, with the kernel edge rows.
`define CONV_UNITS_EDGES (`CONV_UNITS + `CONV_KERNEL_H_MAX - 1)

// pixel bus words, padded to a power of two.
`define CONV_PIXEL_WORDS (2 ** $clog2(`CONV_UNITS_EDGES))

// words on one gathered weight beat.
`define CONV_WEIGHT_WORDS (`CONV_CORES * `CONV_KERNEL_W_MAX)

`define CONV_DMA_BITS       32
`define CONV_DMA_PER_WEIGHT 3 // 12 words over 4 bytes.

`endif
